// File: verilog/cam_pkg.sv
/*
  shared types and register map for the camera vision path
  pixels are rgb444, two sensor bytes per pixel
  x counts up to 1023 columns, y up to 511 lines
  register offsets are byte addresses on an 8-bit apb paddr
*/
package cam_pkg;

  // one pixel colour, 4 bits per channel
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb444_t;

  // pixel with position and end markers
  typedef struct packed {
    logic       valid;
    rgb444_t    colour;
    logic [9:0] x;
    logic [8:0] y;
    logic       line_last;
    logic       frame_last;
  } pix_t;

  // pixel plus colour-window match
  typedef struct packed {
    pix_t pix;
    logic hit;
  } mark_t;

  // orange window, same bit order as REG_WIN[15:0]
  typedef struct packed {
    logic [3:0] r_min;
    logic [3:0] g_min;
    logic [3:0] g_max;
    logic [3:0] b_max;
  } orange_win_t;

  typedef enum logic [1:0] {
    DIR_NONE,
    DIR_LEFT,
    DIR_CENTRE,
    DIR_RIGHT
  } dir_e;

  typedef enum logic [1:0] {
    CAP_WAIT_FRAME,
    CAP_BYTE_HI,
    CAP_BYTE_LO
  } cap_state_e;

  // REG_STATUS[10:0] holds this struct as is
  typedef struct packed {
    dir_e       dir;
    logic       detected;
    logic [7:0] frame_cnt;
  } cam_status_t;

  // register map
  localparam logic [7:0] REG_CTRL    = 8'h00;
  localparam logic [7:0] REG_WIN     = 8'h04;
  localparam logic [7:0] REG_MIN_CNT = 8'h08;
  localparam logic [7:0] REG_STATUS  = 8'h0C;
  localparam logic [7:0] REG_ZONES   = 8'h10;

  // reset values of the writable registers
  localparam orange_win_t WIN_RST     = '{r_min: 4'hC, g_min: 4'h4, g_max: 4'h9, b_max: 4'h3};
  localparam logic [7:0]  MIN_CNT_RST = 8'd4;

endpackage

// File: verilog/ov7670_capture.sv
/*
  ov7670 rgb444 byte capture, pixel clock used as an enable on clk_50
  first byte low nibble is red, second byte is green then blue
  starts only after a falling cam_vsync while enabled
  a line with an odd byte count drops its last byte
*/
`timescale 1ns/100ps

module ov7670_capture #(
  parameter int unsigned FRAME_W = 640,
  parameter int unsigned FRAME_H = 480
) (
  input  logic              clk_50,
  input  logic              arst_n,
  input  logic              enable,
  input  logic              cam_vsync,
  input  logic              cam_href,
  input  logic              cam_pclk_en,
  input  logic [7:0]        cam_data,
  output cam_pkg::pix_t     pix_out
);

  cam_pkg::cap_state_e state;
  logic                vsync_q;
  logic                href_q;
  logic [3:0]          red_q;
  logic [9:0]          x_cnt;
  logic [8:0]          y_cnt;
  logic                pix_vld;
  cam_pkg::rgb444_t    colour_q;
  logic [9:0]          x_q;
  logic [8:0]          y_q;
  logic                line_last_q;
  logic                frame_last_q;
  logic                vsync_fall;
  logic                href_fall;
  logic                byte_en;
  logic                pix_done;

  assign vsync_fall = vsync_q & ~cam_vsync;
  assign href_fall  = href_q & ~cam_href;
  // one sensor byte this cycle
  assign byte_en    = cam_pclk_en & cam_href;
  // second byte of a pixel
  assign pix_done   = byte_en & (state == cam_pkg::CAP_BYTE_LO) & ~cam_vsync & enable;

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      state   <= cam_pkg::CAP_WAIT_FRAME;
      vsync_q <= 1'b1;
      href_q  <= 1'b0;
      x_cnt   <= '0;
      y_cnt   <= '0;
      pix_vld <= 1'b0;
    end else begin
      vsync_q <= cam_vsync;
      href_q  <= cam_href;
      pix_vld <= pix_done;
      // new frame restarts both counters
      if (vsync_fall) begin
        x_cnt <= '0;
        y_cnt <= '0;
      end else if (href_fall) begin
        x_cnt <= '0;
        y_cnt <= y_cnt + 9'd1;
      end else if (pix_done) begin
        x_cnt <= x_cnt + 10'd1;
      end
      if (!enable) begin
        state <= cam_pkg::CAP_WAIT_FRAME;
      end else begin
        case (state)
          cam_pkg::CAP_WAIT_FRAME: if (vsync_fall) state <= cam_pkg::CAP_BYTE_HI;
          cam_pkg::CAP_BYTE_HI: begin
            if (cam_vsync) state <= cam_pkg::CAP_WAIT_FRAME;
            else if (byte_en) state <= cam_pkg::CAP_BYTE_LO;
          end
          cam_pkg::CAP_BYTE_LO: begin
            if (cam_vsync) state <= cam_pkg::CAP_WAIT_FRAME;
            // realign on line end or second byte
            else if (href_fall || byte_en) state <= cam_pkg::CAP_BYTE_HI;
          end
          default: state <= cam_pkg::CAP_WAIT_FRAME;
        endcase
      end
    end
  end

  // pixel payload
  always_ff @(posedge clk_50) begin
    if (byte_en && state == cam_pkg::CAP_BYTE_HI) red_q <= cam_data[3:0];
    if (pix_done) begin
      colour_q     <= '{red: red_q, green: cam_data[7:4], blue: cam_data[3:0]};
      x_q          <= x_cnt;
      y_q          <= y_cnt;
      line_last_q  <= (x_cnt == 10'(FRAME_W - 1));
      frame_last_q <= (x_cnt == 10'(FRAME_W - 1)) && (y_cnt == 9'(FRAME_H - 1));
    end
  end

  assign pix_out = '{valid: pix_vld, colour: colour_q, x: x_q, y: y_q,
                     line_last: line_last_q, frame_last: frame_last_q};

  // two enabled bytes per pixel, so never back to back
  a_no_back_to_back: assert property (@(posedge clk_50) disable iff (!arst_n)
    pix_out.valid |=> !pix_out.valid)
    else $error("capture: pix_out valid in two consecutive cycles");

endmodule

// File: verilog/target_finder.sv
/*
  per-pixel orange test against a programmable window
  red >= r_min, g_min <= green <= g_max, blue <= b_max
  window bounds are inclusive, one cycle of latency
  window changes take effect on the next pixel
*/
`timescale 1ns/100ps

module target_finder (
  input  logic                 clk_50,
  input  logic                 arst_n,
  input  cam_pkg::pix_t        pix_in,
  input  cam_pkg::orange_win_t win,
  output cam_pkg::mark_t       mark_out
);

  cam_pkg::pix_t pix_q;
  logic          vld_q;
  logic          hit_q;
  logic          red_ok;
  logic          green_ok;
  logic          blue_ok;
  logic          in_win;

  // channel checks
  assign red_ok   = pix_in.colour.red >= win.r_min;
  assign green_ok = (pix_in.colour.green >= win.g_min) && (pix_in.colour.green <= win.g_max);
  assign blue_ok  = pix_in.colour.blue <= win.b_max;
  // all three must hold
  assign in_win   = red_ok & green_ok & blue_ok;

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= 1'b0;
      hit_q <= 1'b0;
    end else begin
      vld_q <= pix_in.valid;
      // idle cycles never carry a hit
      hit_q <= pix_in.valid & in_win;
    end
  end

  // payload follows the input unconditionally
  always_ff @(posedge clk_50) begin
    pix_q <= pix_in;
  end

  always_comb begin
    mark_out           = '0;
    mark_out.pix       = pix_q;
    mark_out.pix.valid = vld_q;
    mark_out.hit       = hit_q;
  end

  // a hit needs a valid pixel here and one cycle earlier at the input
  a_hit_needs_valid: assert property (@(posedge clk_50) disable iff (!arst_n)
    mark_out.hit |-> mark_out.pix.valid && $past(pix_in.valid))
    else $error("target_finder: hit without a valid pixel");

endmodule

// File: verilog/direction_classifier.sv
/*
  counts hit pixels in left, centre and right thirds of the frame
  decision and readback counts update one cycle after frame_last
  zone counts saturate at 255, frame count wraps at 256
  ties go to centre, then left, then right
*/
`timescale 1ns/100ps

module direction_classifier #(
  parameter int unsigned FRAME_W = 640
) (
  input  logic                 clk_50,
  input  logic                 arst_n,
  input  cam_pkg::mark_t       mark_in,
  input  logic [7:0]           min_count,
  output cam_pkg::cam_status_t status,
  output logic [7:0]           cnt_left,
  output logic [7:0]           cnt_centre,
  output logic [7:0]           cnt_right
);

  // zone edges in pixels
  localparam logic [9:0] LEFT_END    = 10'(FRAME_W / 3);
  localparam logic [9:0] RIGHT_START = 10'((2 * FRAME_W) / 3);

  logic [7:0]    acc_left;
  logic [7:0]    acc_centre;
  logic [7:0]    acc_right;
  logic [7:0]    nxt_left;
  logic [7:0]    nxt_centre;
  logic [7:0]    nxt_right;
  logic [9:0]    total;
  logic          hit_pix;
  logic          in_left;
  logic          in_right;
  logic          frame_end;
  cam_pkg::dir_e dir_nxt;
  logic          det_nxt;

  function automatic logic [7:0] sat_inc(input logic [7:0] v, input logic en);
    sat_inc = (en && v != 8'hFF) ? v + 8'd1 : v;
  endfunction

  assign hit_pix   = mark_in.pix.valid & mark_in.hit;
  assign in_left   = mark_in.pix.x < LEFT_END;
  assign in_right  = mark_in.pix.x >= RIGHT_START;
  assign frame_end = mark_in.pix.valid & mark_in.pix.frame_last;

  // counts including the current pixel
  assign nxt_left   = sat_inc(acc_left, hit_pix & in_left);
  assign nxt_centre = sat_inc(acc_centre, hit_pix & ~in_left & ~in_right);
  assign nxt_right  = sat_inc(acc_right, hit_pix & in_right);
  assign total      = 10'(nxt_left) + 10'(nxt_centre) + 10'(nxt_right);

  always_comb begin
    det_nxt = 1'b1;
    if (total < 10'(min_count)) begin
      dir_nxt = cam_pkg::DIR_NONE;
      det_nxt = 1'b0;
    end else if (nxt_centre >= nxt_left && nxt_centre >= nxt_right) begin
      dir_nxt = cam_pkg::DIR_CENTRE;
    end else if (nxt_left >= nxt_right) begin
      dir_nxt = cam_pkg::DIR_LEFT;
    end else begin
      dir_nxt = cam_pkg::DIR_RIGHT;
    end
  end

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      acc_left   <= '0;
      acc_centre <= '0;
      acc_right  <= '0;
      cnt_left   <= '0;
      cnt_centre <= '0;
      cnt_right  <= '0;
      status     <= '{dir: cam_pkg::DIR_NONE, detected: 1'b0, frame_cnt: 8'd0};
    end else if (frame_end) begin
      // latch result, start next frame from zero
      acc_left         <= '0;
      acc_centre       <= '0;
      acc_right        <= '0;
      cnt_left         <= nxt_left;
      cnt_centre       <= nxt_centre;
      cnt_right        <= nxt_right;
      status.dir       <= dir_nxt;
      status.detected  <= det_nxt;
      status.frame_cnt <= status.frame_cnt + 8'd1;
    end else begin
      acc_left   <= nxt_left;
      acc_centre <= nxt_centre;
      acc_right  <= nxt_right;
    end
  end

endmodule

// File: verilog/cam_apb_regs.sv
/*
  apb slave for the vision path, pready tied high
  CTRL[0] enable, WIN[15:0] r_min g_min g_max b_max, MIN_CNT[7:0]
  STATUS [10:9] direction, [8] detected, [7:0] frame count
  ZONES [7:0] left, [15:8] centre, [23:16] right
  pslverr on unmapped address or write to STATUS or ZONES
*/
`timescale 1ns/100ps

module cam_apb_regs (
  input  logic                 clk_50,
  input  logic                 arst_n,
  input  logic [7:0]           paddr,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [31:0]          pwdata,
  input  cam_pkg::cam_status_t status,
  input  logic [7:0]           cnt_left,
  input  logic [7:0]           cnt_centre,
  input  logic [7:0]           cnt_right,
  output logic [31:0]          prdata,
  output logic                 pready,
  output logic                 pslverr,
  output logic                 enable,
  output cam_pkg::orange_win_t win,
  output logic [7:0]           min_count
);

  logic access_ph;
  logic addr_ok;
  logic addr_ro;
  logic wr_en;

  assign access_ph = psel & penable;

  // address decode and read mux
  always_comb begin
    prdata  = '0;
    addr_ok = 1'b1;
    addr_ro = 1'b0;
    case (paddr)
      cam_pkg::REG_CTRL:    prdata = {31'd0, enable};
      cam_pkg::REG_WIN:     prdata = {16'd0, win};
      cam_pkg::REG_MIN_CNT: prdata = {24'd0, min_count};
      cam_pkg::REG_STATUS: begin
        prdata  = {21'd0, status};
        addr_ro = 1'b1;
      end
      cam_pkg::REG_ZONES: begin
        prdata  = {8'd0, cnt_right, cnt_centre, cnt_left};
        addr_ro = 1'b1;
      end
      default: addr_ok = 1'b0;
    endcase
  end

  assign wr_en   = access_ph & pwrite & addr_ok & ~addr_ro;
  assign pready  = 1'b1;
  // error only in the access phase
  assign pslverr = access_ph & (~addr_ok | (pwrite & addr_ro));

  always_ff @(posedge clk_50 or negedge arst_n) begin
    if (!arst_n) begin
      enable    <= 1'b0;
      win       <= cam_pkg::WIN_RST;
      min_count <= cam_pkg::MIN_CNT_RST;
    end else if (wr_en) begin
      case (paddr)
        cam_pkg::REG_CTRL:    enable    <= pwdata[0];
        cam_pkg::REG_WIN:     win       <= cam_pkg::orange_win_t'(pwdata[15:0]);
        cam_pkg::REG_MIN_CNT: min_count <= pwdata[7:0];
        default: ;
      endcase
    end
  end

  // access phase must follow a setup cycle
  a_apb_setup: assert property (@(posedge clk_50) disable iff (!arst_n)
    psel && penable |-> $past(psel && !penable))
    else $error("cam_apb_regs: penable without a setup cycle");

endmodule

// File: verilog/cam_vision_top.sv
/*
  camera vision path: capture, orange finder, direction classifier
  single clock, cam_pclk_en marks each sensor byte on clk_50
  mark_out lags the second byte of a pixel by two cycles
  no back-pressure, the sensor stream cannot stall
*/
`timescale 1ns/100ps

module cam_vision_top #(
  parameter int unsigned FRAME_W = 640,
  parameter int unsigned FRAME_H = 480
) (
  input  logic           clk_50,
  input  logic           arst_n,
  // sensor
  input  logic           cam_vsync,
  input  logic           cam_href,
  input  logic           cam_pclk_en,
  input  logic [7:0]     cam_data,
  // apb
  input  logic [7:0]     paddr,
  input  logic           psel,
  input  logic           penable,
  input  logic           pwrite,
  input  logic [31:0]    pwdata,
  output logic [31:0]    prdata,
  output logic           pready,
  output logic           pslverr,
  // marked pixel stream
  output cam_pkg::mark_t mark_out
);

  logic                 enable;
  logic [7:0]           min_count;
  logic [7:0]           cnt_left;
  logic [7:0]           cnt_centre;
  logic [7:0]           cnt_right;
  cam_pkg::orange_win_t win;
  cam_pkg::cam_status_t status;
  cam_pkg::pix_t        pix;

  ov7670_capture #(
    .FRAME_W(FRAME_W),
    .FRAME_H(FRAME_H)
  ) u_ov7670_capture (
    .clk_50(clk_50), .arst_n(arst_n), .enable(enable),
    .cam_vsync(cam_vsync), .cam_href(cam_href), .cam_pclk_en(cam_pclk_en),
    .cam_data(cam_data), .pix_out(pix)
  );

  target_finder u_target_finder (
    .clk_50(clk_50), .arst_n(arst_n), .pix_in(pix), .win(win), .mark_out(mark_out)
  );

  direction_classifier #(
    .FRAME_W(FRAME_W)
  ) u_direction_classifier (
    .clk_50(clk_50), .arst_n(arst_n), .mark_in(mark_out), .min_count(min_count),
    .status(status), .cnt_left(cnt_left), .cnt_centre(cnt_centre), .cnt_right(cnt_right)
  );

  cam_apb_regs u_cam_apb_regs (
    .clk_50(clk_50), .arst_n(arst_n), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .status(status), .cnt_left(cnt_left),
    .cnt_centre(cnt_centre), .cnt_right(cnt_right), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .enable(enable), .win(win), .min_count(min_count)
  );

endmodule

// File: dv/cam_vision_tb.sv
/*
  testbench for cam_vision_top with a 12 x 4 frame
  tests come from dv/cam_vision_stim.txt, run from the project root
  one sensor byte every second clk_50 cycle, no back-pressure
  status and zones are read over apb after each frame
*/
`timescale 1ns/100ps

module cam_vision_tb;

  localparam int    FRAME_W   = 12;
  localparam int    FRAME_H   = 4;
  localparam string STIM_FILE = "dv/cam_vision_stim.txt";

  logic                 clk_50;
  logic                 arst_n;
  logic                 cam_vsync;
  logic                 cam_href;
  logic                 cam_pclk_en;
  logic [7:0]           cam_data;
  logic [7:0]           paddr;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [31:0]          pwdata;
  logic [31:0]          prdata;
  logic                 pready;
  logic                 pslverr;
  cam_pkg::mark_t       mark_out;

  // expected marked pixels, oldest first
  cam_pkg::mark_t       exp_q[$];
  string                cur_test;
  int                   err_cnt;
  int                   test_cnt;
  int                   test_fail;
  int                   exp_frames;
  int                   stim_fd;
  logic [7:0]           exp_left;
  logic [7:0]           exp_centre;
  logic [7:0]           exp_right;
  cam_pkg::orange_win_t cur_win;
  logic [11:0]          frame_pix [FRAME_W*FRAME_H];

  cam_vision_top #(
    .FRAME_W(FRAME_W),
    .FRAME_H(FRAME_H)
  ) u_cam_vision_top (
    .clk_50(clk_50), .arst_n(arst_n), .cam_vsync(cam_vsync), .cam_href(cam_href),
    .cam_pclk_en(cam_pclk_en), .cam_data(cam_data), .paddr(paddr), .psel(psel),
    .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
    .pready(pready), .pslverr(pslverr), .mark_out(mark_out)
  );

  initial begin
    clk_50 = 1'b0;
    forever #5 clk_50 = ~clk_50;
  end

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("FAIL %s %s expected %0h actual %0h", cur_test, what, exp, act);
    err_cnt++;
  endtask

  // plan rule for an orange pixel
  function automatic logic in_window(input logic [11:0] c, input cam_pkg::orange_win_t w);
    return (c[11:8] >= w.r_min) && (c[7:4] >= w.g_min) && (c[7:4] <= w.g_max) &&
           (c[3:0] <= w.b_max);
  endfunction

  // sampled at posedge, before this edge's register updates
  always @(posedge clk_50) begin : mark_monitor
    cam_pkg::mark_t exp_m;
    if (arst_n && mark_out.pix.valid) begin
      if (exp_q.size() == 0) begin
        $display("ERROR %s: mark_out valid without a pixel sent", cur_test);
        err_cnt++;
      end else begin
        exp_m = exp_q.pop_front();
        if (mark_out.pix != exp_m.pix) report_mismatch("pixel", 64'(exp_m.pix), 64'(mark_out.pix));
        if (mark_out.hit != exp_m.hit) report_mismatch("hit", 64'(exp_m.hit), 64'(mark_out.hit));
      end
    end
  end

  // setup then access phase, result taken when pready is seen
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int n;
    bit done;
    rdata = '0;
    err   = 1'b0;
    n     = 0;
    done  = 0;
    @(negedge clk_50);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk_50);
    penable = 1'b1;
    while (!done && n < 16) begin
      @(posedge clk_50);
      if (pready) begin
        rdata = prdata;
        err   = pslverr;
        done  = 1;
      end
      n++;
    end
    if (!done) begin
      $display("ERROR %s: apb access to %0h never saw pready", cur_test, addr);
      err_cnt++;
    end
    @(negedge clk_50);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    if (err) begin
      $display("ERROR %s: write to %0h returned pslverr", cur_test, addr);
      err_cnt++;
    end
  endtask

  task automatic check_reg(input string what, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b0, addr, 32'd0, rd, err);
    if (err) begin
      $display("ERROR %s: read of %0h returned pslverr", cur_test, addr);
      err_cnt++;
    end
    if (rd !== exp) report_mismatch(what, 64'(exp), 64'(rd));
  endtask

  task automatic check_error(input logic wr, input logic [7:0] addr, input string what);
    logic [31:0] rd;
    logic        err;
    apb_access(wr, addr, 32'hFFFF_FFFF, rd, err);
    if (!err) begin
      $display("ERROR %s: no pslverr on %s", cur_test, what);
      err_cnt++;
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    cam_data    = b;
    cam_pclk_en = 1'b1;
    @(negedge clk_50);
    cam_pclk_en = 1'b0;
    @(negedge clk_50);
  endtask

  // one frame from frame_pix, expectations queued only when enabled
  task automatic send_frame(input bit en);
    cam_pkg::mark_t m;
    logic [11:0]    c;
    int             x;
    int             y;
    @(negedge clk_50);
    cam_vsync   = 1'b1;
    cam_href    = 1'b0;
    cam_pclk_en = 1'b0;
    repeat (3) @(negedge clk_50);
    cam_vsync = 1'b0;
    repeat (2) @(negedge clk_50);
    for (y = 0; y < FRAME_H; y++) begin
      cam_href = 1'b1;
      for (x = 0; x < FRAME_W; x++) begin
        c = frame_pix[y*FRAME_W + x];
        m.pix.valid      = 1'b1;
        m.pix.colour     = cam_pkg::rgb444_t'(c);
        m.pix.x          = 10'(x);
        m.pix.y          = 9'(y);
        m.pix.line_last  = (x == FRAME_W - 1);
        m.pix.frame_last = (x == FRAME_W - 1) && (y == FRAME_H - 1);
        m.hit            = in_window(c, cur_win);
        if (en && m.hit) begin
          if (x < FRAME_W / 3) exp_left++;
          else if (x >= (2 * FRAME_W) / 3) exp_right++;
          else exp_centre++;
        end
        // high nibble of the first byte is unused, x goes there
        send_byte({x[3:0], c[11:8]});
        if (en) exp_q.push_back(m);
        send_byte(c[7:0]);
      end
      cam_href = 1'b0;
      repeat (3) @(negedge clk_50);
    end
  endtask

  task automatic run_test(input logic [15:0] w, input logic [7:0] min_v, input bit en,
                          input int dir_v, input bit det_v);
    logic [31:0]          rd;
    logic                 err;
    cam_pkg::cam_status_t st;
    int                   n;
    bit                   done;
    cur_win    = cam_pkg::orange_win_t'(w);
    exp_left   = '0;
    exp_centre = '0;
    exp_right  = '0;
    reg_write(cam_pkg::REG_WIN, {16'd0, w});
    reg_write(cam_pkg::REG_MIN_CNT, {24'd0, min_v});
    reg_write(cam_pkg::REG_CTRL, {31'd0, en});
    check_reg("win readback", cam_pkg::REG_WIN, {16'd0, w});
    send_frame(en);
    if (en) exp_frames++;
    n = 0;
    while (exp_q.size() != 0 && n < 64) begin
      @(posedge clk_50);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("ERROR %s: %0d marked pixels never came out", cur_test, exp_q.size());
      err_cnt++;
      exp_q.delete();
    end
    // status lands one cycle after frame_last
    done = 0;
    n    = 0;
    st   = '0;
    while (!done && n < 8) begin
      apb_access(1'b0, cam_pkg::REG_STATUS, 32'd0, rd, err);
      st   = cam_pkg::cam_status_t'(rd[10:0]);
      done = (st.frame_cnt == exp_frames[7:0]);
      n++;
    end
    if (!done) report_mismatch("frame count", 64'(exp_frames[7:0]), 64'(st.frame_cnt));
    if (en) begin
      if (st.dir != cam_pkg::dir_e'(dir_v[1:0])) begin
        report_mismatch("direction", 64'(dir_v), 64'(st.dir));
      end
      if (st.detected != det_v) report_mismatch("detected", 64'(det_v), 64'(st.detected));
      check_reg("zones", cam_pkg::REG_ZONES, {8'd0, exp_right, exp_centre, exp_left});
    end
  endtask

  // next line that is neither blank nor a comment
  task automatic next_line(output string line, output bit got);
    int rc;
    got = 0;
    while (!got && !$feof(stim_fd)) begin
      rc = $fgets(line, stim_fd);
      if (rc > 1 && line.getc(0) != "#") got = 1;
    end
  endtask

  task automatic finish_test(input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %s: ok", cur_test);
    end else begin
      test_fail++;
      $display("test %s: %0d errors", cur_test, err_cnt - errs_before);
    end
  endtask

  initial begin
    string       line;
    string       name;
    logic [15:0] win_v;
    logic [7:0]  min_v;
    logic [11:0] c;
    int          en_v;
    int          dir_v;
    int          det_v;
    int          rc;
    int          x;
    int          y;
    int          errs_before;
    bit          got;
    bit          ok;
    arst_n      = 1'b0;
    cam_vsync   = 1'b1;
    cam_href    = 1'b0;
    cam_pclk_en = 1'b0;
    cam_data    = '0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    err_cnt     = 0;
    test_cnt    = 0;
    test_fail   = 0;
    exp_frames  = 0;
    cur_win     = cam_pkg::WIN_RST;
    cur_test    = "reg_reset";
    repeat (2) @(posedge clk_50);
    @(negedge clk_50);
    arst_n = 1'b1;

    errs_before = err_cnt;
    check_reg("ctrl", cam_pkg::REG_CTRL, 32'd0);
    check_reg("win", cam_pkg::REG_WIN, 32'h0000_C493);
    check_reg("min_cnt", cam_pkg::REG_MIN_CNT, 32'd4);
    check_reg("status", cam_pkg::REG_STATUS, 32'd0);
    check_reg("zones", cam_pkg::REG_ZONES, 32'd0);
    check_error(1'b1, cam_pkg::REG_STATUS, "write to the status register");
    check_error(1'b0, 8'h20, "read of an unmapped address");
    check_reg("status after write", cam_pkg::REG_STATUS, 32'd0);
    finish_test(errs_before);

    stim_fd = $fopen(STIM_FILE, "r");
    if (stim_fd == 0) begin
      $display("ERROR: cannot open %s", STIM_FILE);
      err_cnt++;
    end else begin
      next_line(line, got);
      while (got) begin
        rc = $sscanf(line, "%s %h %h %d %d %d", name, win_v, min_v, en_v, dir_v, det_v);
        ok = (rc == 6);
        // four lines of twelve 3-digit pixels
        for (y = 0; y < FRAME_H && ok; y++) begin
          next_line(line, got);
          ok = got && (line.len() >= 4 * FRAME_W - 1);
          for (x = 0; x < FRAME_W && ok; x++) begin
            rc = $sscanf(line.substr(4 * x, 4 * x + 2), "%h", c);
            ok = (rc == 1);
            frame_pix[y*FRAME_W + x] = c;
          end
        end
        if (!ok) begin
          $display("ERROR: stimulus block after test %s is malformed", cur_test);
          err_cnt++;
          got = 0;
        end else begin
          cur_test    = name;
          errs_before = err_cnt;
          run_test(win_v, min_v, en_v[0], dir_v, det_v[0]);
          finish_test(errs_before);
          next_line(line, got);
        end
      end
      $fclose(stim_fd);
    end

    $display("tests %0d, failed %0d, failed checks %0d", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: cam_vision_top.f
verilog/cam_pkg.sv
verilog/ov7670_capture.sv
verilog/target_finder.sv
verilog/direction_classifier.sv
verilog/cam_apb_regs.sv
verilog/cam_vision_top.sv
dv/cam_vision_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the cam_vision testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Simulation finished: FAIL"

verilator --binary --timing --assert -Wno-fatal \
  --top-module cam_vision_tb -f cam_vision_top.f -o cam_vision_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/cam_vision_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
  exit 1
fi
exit 0

// File: dv/cam_vision_stim.txt
# header: name window(r_min g_min g_max b_max hex) min_count(hex) enable exp_dir exp_detected
# then 4 lines of 12 rgb444 pixels; exp_dir 0 none, 1 left, 2 centre, 3 right
centre_bounds C493 04 1 2 1
000 C43 B60 000 C93 E60 000 C33 000 CA3 000 C64
000 000 000 000 F90 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 F43 000 000 000

left_new_win 82A5 04 1 1 1
800 820 8A5 8B5 000 000 000 000 000 000 000 000
930 930 746 000 000 000 000 000 000 000 000 000
000 000 000 000 936 000 000 000 000 000 000 000
000 000 000 000 935 000 000 000 935 935 000 000

tie_centre_left C493 04 1 2 1
E60 E60 000 000 E60 E60 000 000 E60 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000

tie_left_right C493 04 1 1 1
E60 000 000 000 000 E60 000 000 E60 000 000 000
E60 000 000 000 000 000 000 000 E60 000 000 000
E60 000 000 000 000 000 000 000 000 000 000 E60
000 000 000 000 000 000 000 000 000 000 000 000

right_zone C493 04 1 3 1
E60 000 000 000 E60 000 000 000 000 000 000 E60
000 000 000 000 000 000 000 000 000 000 E60 000
000 000 000 000 000 000 000 000 E60 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000

below_min C493 06 1 0 0
E60 E60 000 000 000 E60 000 000 000 E60 E60 000
000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000

disabled C493 04 0 0 0
E60 E60 E60 E60 E60 E60 E60 E60 E60 E60 E60 E60
000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000
